/* verilog.f */
rtl/adxl_pkg.sv
rtl/ctrl_pkg.sv
rtl/spi_byte_if.sv
rtl/spi_byte_engine.sv
rtl/adxl_sampler.sv
rtl/pedal_quantizer.sv
rtl/wheel_quantizer.sv
rtl/drive_controls.sv
bench/adxl345_model.sv
bench/tb_drive_controls.sv

/* Bender.yml */
package:
  name: drive_controls

sources:
  - rtl/adxl_pkg.sv
  - rtl/ctrl_pkg.sv
  - rtl/spi_byte_if.sv
  - rtl/spi_byte_engine.sv
  - rtl/adxl_sampler.sv
  - rtl/pedal_quantizer.sv
  - rtl/wheel_quantizer.sv
  - rtl/drive_controls.sv
  - target: test
    files:
      - bench/adxl345_model.sv
      - bench/tb_drive_controls.sv

/* bench/tb_drive_controls.sv */
module tb_drive_controls;
    import adxl_pkg::*;
    import ctrl_pkg::*;

    localparam int RANDOM_SAMPLES    = 40;
    localparam int CYCLES_PER_SAMPLE = 500;

    logic                            clk = 1'b0;
    logic                            arst_n;
    logic                            pedal_cs;
    logic                            pedal_spc;
    logic                            pedal_sdi;
    logic                            pedal_sdo;
    logic                            wheel_cs;
    logic                            wheel_spc;
    logic                            wheel_sdi;
    logic                            wheel_sdo;
    logic signed [ACC_W-1:0]         pedal_bound [PEDAL_BOUNDS];
    logic signed [ACC_W-1:0]         wheel_bound [WHEEL_BOUNDS];
    logic signed [ACC_W-1:0]         pedal_acc;
    logic [PEDAL_LEVEL_W-1:0]        pedal_level;
    logic                            pedal_update;
    logic signed [WHEEL_LEVEL_W-1:0] wheel_level;
    logic                            wheel_update;
    logic signed [ACC_W-1:0]         pedal_x;
    logic signed [ACC_W-1:0]         pedal_y;
    logic signed [ACC_W-1:0]         wheel_x;
    logic signed [ACC_W-1:0]         wheel_y;
    logic [7:0]                      pedal_wr_cnt;
    logic [15:0]                     pedal_wr0;
    logic [15:0]                     pedal_wr1;
    logic [7:0]                      wheel_wr_cnt;
    logic [15:0]                     wheel_wr0;
    logic [15:0]                     wheel_wr1;

    // served samples in order with one entry per expected update.
    logic signed [ACC_W-1:0] pedal_y_q [$];
    string                   pedal_name [$];
    logic signed [ACC_W-1:0] wheel_x_q [$];
    logic signed [ACC_W-1:0] wheel_y_q [$];
    string                   wheel_name [$];

    int          pedal_seen = 0;
    int          wheel_seen = 0;
    int          cycles = 0;
    int          limit = 0;
    logic [31:0] rng = 32'd47;

    drive_controls uut (
        .i_clk          (clk),
        .i_arst_n       (arst_n),
        .o_pedal_cs     (pedal_cs),
        .o_pedal_spc    (pedal_spc),
        .o_pedal_sdi    (pedal_sdi),
        .i_pedal_sdo    (pedal_sdo),
        .o_wheel_cs     (wheel_cs),
        .o_wheel_spc    (wheel_spc),
        .o_wheel_sdi    (wheel_sdi),
        .i_wheel_sdo    (wheel_sdo),
        .i_pedal_bound  (pedal_bound),
        .i_wheel_bound  (wheel_bound),
        .o_pedal_acc    (pedal_acc),
        .o_pedal_level  (pedal_level),
        .o_pedal_update (pedal_update),
        .o_wheel_level  (wheel_level),
        .o_wheel_update (wheel_update)
    );

    adxl345_model pedal_model (
        .i_cs           (pedal_cs),
        .i_spc          (pedal_spc),
        .i_sdi          (pedal_sdi),
        .o_sdo          (pedal_sdo),
        .i_x            (pedal_x),
        .i_y            (pedal_y),
        .o_write_cnt    (pedal_wr_cnt),
        .o_first_write  (pedal_wr0),
        .o_second_write (pedal_wr1)
    );

    adxl345_model wheel_model (
        .i_cs           (wheel_cs),
        .i_spc          (wheel_spc),
        .i_sdi          (wheel_sdi),
        .o_sdo          (wheel_sdo),
        .i_x            (wheel_x),
        .i_y            (wheel_y),
        .o_write_cnt    (wheel_wr_cnt),
        .o_first_write  (wheel_wr0),
        .o_second_write (wheel_wr1)
    );

    always #10 clk = ~clk;

    // ==============================
    // reference model
    // ==============================
    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [PEDAL_LEVEL_W-1:0] pedal_ref(input logic signed [ACC_W-1:0] acc);
        for (int i = 0; i < PEDAL_BOUNDS; i++) begin
            if (acc > pedal_bound[i]) begin
                return PEDAL_LEVEL_W'(i);
            end
        end
        return 3'd7;
    endfunction

    function automatic logic signed [WHEEL_LEVEL_W-1:0] wheel_ref(
        input logic signed [ACC_W-1:0] x,
        input logic signed [ACC_W-1:0] y
    );
        int ax;
        int mag;
        ax  = (x < 0) ? -int'(x) : int'(x);
        mag = 0;
        // tipped past upright.
        if (y > 0 && ax > wheel_bound[0]) begin
            return 4'sd7;
        end
        for (int i = 0; i < WHEEL_BOUNDS; i++) begin
            if (ax > wheel_bound[i]) begin
                mag++;
            end
        end
        return (x < 0) ? 4'(-mag) : 4'(mag);
    endfunction

    // ==============================
    // checking
    // ==============================
    task automatic stop_run(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string test, input int expected, input int actual);
        assert (actual == expected)
            else stop_run($sformatf("Fail %s: expected %0d, actual %0d", test, expected, actual));
    endtask

    // data format 0x31 gets 0x0B and then power ctl 0x2D gets 0x08.
    task automatic check_config(input string sensor, input int cnt,
                                input logic [15:0] first, input logic [15:0] second);
        assert (cnt == 2)
            else stop_run({sensor, " sensor did not get both configuration writes"});
        assert (first == 16'h310B)
            else stop_run({sensor, " sensor: first write is not full resolution to DATA_FORMAT"});
        assert (second == 16'h2D08)
            else stop_run({sensor, " sensor: second write is not measure mode to POWER_CTL"});
    endtask

    // both sensors keep polling after the end of the shorter list.
    always @(negedge clk) begin
        if (pedal_update && pedal_seen < pedal_y_q.size()) begin
            check_value({pedal_name[pedal_seen], " acc"}, pedal_y_q[pedal_seen], pedal_acc);
            check_value({pedal_name[pedal_seen], " level"},
                        pedal_ref(pedal_y_q[pedal_seen]), pedal_level);
            pedal_seen++;
        end
        if (wheel_update && wheel_seen < wheel_x_q.size()) begin
            check_value({wheel_name[wheel_seen], " level"},
                        wheel_ref(wheel_x_q[wheel_seen], wheel_y_q[wheel_seen]), wheel_level);
            wheel_seen++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            stop_run("timeout, the DUT stopped producing updates");
        end
    end

    // ==============================
    // stimulus
    // ==============================
    task automatic add_pedal(input string name, input int y);
        pedal_y_q.push_back(16'(y));
        pedal_name.push_back(name);
    endtask

    task automatic add_wheel(input string name, input int x, input int y);
        wheel_x_q.push_back(16'(x));
        wheel_y_q.push_back(16'(y));
        wheel_name.push_back(name);
    endtask

    task automatic build_stimulus();
        for (int i = 0; i < PEDAL_BOUNDS; i++) begin
            for (int d = -1; d <= 1; d++) begin
                add_pedal("pedal sweep", pedal_bound[i] + d);
            end
        end
        add_pedal("pedal extreme", 32767);
        add_pedal("pedal extreme", -32768);
        for (int i = 0; i < WHEEL_BOUNDS; i++) begin
            for (int d = -1; d <= 1; d++) begin
                add_wheel("wheel sweep", wheel_bound[i] + d, -200);
                add_wheel("wheel sweep", -(wheel_bound[i] + d), -200);
            end
        end
        add_wheel("wheel extreme", 0, 0);
        add_wheel("wheel extreme", 32767, 0);
        add_wheel("wheel extreme", -32768, 0);
        add_wheel("wheel tipped", wheel_bound[0] + 1, 500);
        add_wheel("wheel tipped", -(wheel_bound[0] + 1), 500);
        add_wheel("wheel tipped", wheel_bound[0], 500);
        add_wheel("wheel tipped", -wheel_bound[0], 32767);
        add_wheel("wheel tipped", 0, 500);
        for (int k = 0; k < RANDOM_SAMPLES; k++) begin
            rng = xorshift(rng);
            add_pedal("pedal random", rng[15:0]);
            rng = xorshift(rng);
            add_wheel("wheel random", rng[31:16], rng[15:0]);
        end
    endtask

    // a new value goes out only after the previous frame while cs is high.
    task automatic drive_pedal();
        for (int k = 0; k < pedal_y_q.size(); k++) begin
            pedal_y = pedal_y_q[k];
            pedal_x = ~pedal_y_q[k];
            do @(negedge clk); while (!pedal_update);
            do @(negedge clk); while (!pedal_cs);
        end
    endtask

    task automatic drive_wheel();
        for (int k = 0; k < wheel_x_q.size(); k++) begin
            wheel_x = wheel_x_q[k];
            wheel_y = wheel_y_q[k];
            do @(negedge clk); while (!wheel_update);
            do @(negedge clk); while (!wheel_cs);
        end
    endtask

    initial begin
        arst_n      = 1'b0;
        pedal_x     = '0;
        pedal_y     = '0;
        wheel_x     = '0;
        wheel_y     = '0;
        pedal_bound = '{12000, 8000, 4000, 1000, -1000, -4000, -8000};
        wheel_bound = '{1000, 3000, 6000, 10000, 16000};
        build_stimulus();
        limit = (wheel_x_q.size() > pedal_y_q.size()) ? wheel_x_q.size() : pedal_y_q.size();
        limit = (limit + 4) * CYCLES_PER_SAMPLE;
        repeat (4) @(negedge clk);
        assert (pedal_cs && pedal_spc && !pedal_sdi && wheel_cs && wheel_spc && !wheel_sdi)
            else stop_run("SPI buses are not idle after reset");
        assert (!pedal_update && !wheel_update)
            else stop_run("an update pulse is high during reset");
        check_value("reset pedal level", 0, pedal_level);
        check_value("reset wheel level", 0, wheel_level);
        arst_n = 1'b1;
        fork
            drive_pedal();
            drive_wheel();
        join
        check_config("pedal", pedal_wr_cnt, pedal_wr0, pedal_wr1);
        check_config("wheel", wheel_wr_cnt, wheel_wr0, wheel_wr1);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* bench/adxl345_model.sv */
module adxl345_model (
    input  logic        i_cs,
    input  logic        i_spc,
    input  logic        i_sdi,
    output logic        o_sdo,
    input  logic [15:0] i_x,
    input  logic [15:0] i_y,
    output logic [7:0]  o_write_cnt,
    output logic [15:0] o_first_write,
    output logic [15:0] o_second_write
);

    int         nbits;
    logic [7:0] shift_in;
    logic [7:0] cmd;
    logic [7:0] rd_byte;

    initial begin
        nbits          = 0;
        shift_in       = '0;
        cmd            = '0;
        rd_byte        = '0;
        o_sdo          = 1'b0;
        o_write_cnt    = '0;
        o_first_write  = '0;
        o_second_write = '0;
    end

    // X0 X1 Y0 Y1, little-endian.
    function automatic logic [7:0] read_reg(input logic [5:0] addr);
        case (addr)
            6'h32:   return i_x[7:0];
            6'h33:   return i_x[15:8];
            6'h34:   return i_y[7:0];
            6'h35:   return i_y[15:8];
            default: return 8'h00;
        endcase
    endfunction

    // a frame ends when cs rises.
    always @(posedge i_cs) begin
        nbits = 0;
    end

    // sdi is taken on the rising spc edge.
    always @(posedge i_spc) begin
        if (i_cs === 1'b0) begin
            shift_in = {shift_in[6:0], i_sdi};
            nbits    = nbits + 1;
            if (nbits == 8) begin
                cmd = shift_in;
            end else if (nbits == 16 && !cmd[7] && o_write_cnt < 2) begin
                if (o_write_cnt == 0) begin
                    o_first_write = {cmd, shift_in};
                end else begin
                    o_second_write = {cmd, shift_in};
                end
                o_write_cnt = o_write_cnt + 1'b1;
            end
        end
    end

    // sdo moves on the falling spc edge, register address steps with MB set.
    always @(negedge i_spc) begin
        if (i_cs === 1'b0 && cmd[7] && nbits >= 8) begin
            rd_byte = read_reg(cmd[5:0] + (cmd[6] ? 6'(nbits / 8 - 1) : 6'd0));
            o_sdo   = rd_byte[7 - nbits % 8];
        end else begin
            o_sdo = 1'b0;
        end
    end

endmodule

/* rtl/drive_controls.sv */
module drive_controls (
    input  logic                                        i_clk,
    input  logic                                        i_arst_n,
    // pedal sensor bus.
    output logic                                        o_pedal_cs,
    output logic                                        o_pedal_spc,
    output logic                                        o_pedal_sdi,
    input  logic                                        i_pedal_sdo,
    // wheel sensor bus.
    output logic                                        o_wheel_cs,
    output logic                                        o_wheel_spc,
    output logic                                        o_wheel_sdi,
    input  logic                                        i_wheel_sdo,
    input  logic signed [adxl_pkg::ACC_W-1:0]           i_pedal_bound [ctrl_pkg::PEDAL_BOUNDS],
    input  logic signed [adxl_pkg::ACC_W-1:0]           i_wheel_bound [ctrl_pkg::WHEEL_BOUNDS],
    output logic signed [adxl_pkg::ACC_W-1:0]           o_pedal_acc,
    output logic [ctrl_pkg::PEDAL_LEVEL_W-1:0]          o_pedal_level,
    output logic                                        o_pedal_update,
    output logic signed [ctrl_pkg::WHEEL_LEVEL_W-1:0]   o_wheel_level,
    output logic                                        o_wheel_update
);
    import adxl_pkg::*;

    logic                    pedal_valid;
    logic                    wheel_valid;
    logic signed [ACC_W-1:0] wheel_x;
    logic signed [ACC_W-1:0] wheel_y;

    spi_byte_if pedal_bus ();
    spi_byte_if wheel_bus ();

    // ==============================
    // pedal, Y axis only
    // ==============================
    spi_byte_engine u_pedal_engine (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .bus      (pedal_bus.engine),
        .o_cs     (o_pedal_cs),
        .o_spc    (o_pedal_spc),
        .o_sdi    (o_pedal_sdi),
        .i_sdo    (i_pedal_sdo)
    );

    adxl_sampler u_pedal_sampler (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .bus            (pedal_bus.master),
        .o_sample_valid (pedal_valid),
        .o_acc_x        (),
        .o_acc_y        (o_pedal_acc)
    );

    pedal_quantizer u_pedal_quantizer (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_sample_valid (pedal_valid),
        .i_acc          (o_pedal_acc),
        .i_lower_bound  (i_pedal_bound),
        .o_level        (o_pedal_level),
        .o_update       (o_pedal_update)
    );

    // ==============================
    // wheel
    // ==============================
    spi_byte_engine u_wheel_engine (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .bus      (wheel_bus.engine),
        .o_cs     (o_wheel_cs),
        .o_spc    (o_wheel_spc),
        .o_sdi    (o_wheel_sdi),
        .i_sdo    (i_wheel_sdo)
    );

    adxl_sampler u_wheel_sampler (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .bus            (wheel_bus.master),
        .o_sample_valid (wheel_valid),
        .o_acc_x        (wheel_x),
        .o_acc_y        (wheel_y)
    );

    wheel_quantizer u_wheel_quantizer (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_sample_valid (wheel_valid),
        .i_acc_x        (wheel_x),
        .i_acc_y        (wheel_y),
        .i_x_bound      (i_wheel_bound),
        .o_level        (o_wheel_level),
        .o_update       (o_wheel_update)
    );

endmodule

/* rtl/wheel_quantizer.sv */
module wheel_quantizer (
    input  logic                                        i_clk,
    input  logic                                        i_arst_n,
    input  logic                                        i_sample_valid,
    input  logic signed [adxl_pkg::ACC_W-1:0]           i_acc_x,
    input  logic signed [adxl_pkg::ACC_W-1:0]           i_acc_y,
    input  logic signed [adxl_pkg::ACC_W-1:0]           i_x_bound [ctrl_pkg::WHEEL_BOUNDS],
    output logic signed [ctrl_pkg::WHEEL_LEVEL_W-1:0]   o_level,
    output logic                                        o_update
);
    import adxl_pkg::*;
    import ctrl_pkg::*;

    logic signed [ACC_W:0]           abs_x;
    logic signed [WHEEL_LEVEL_W-1:0] mag;
    logic signed [WHEEL_LEVEL_W-1:0] level_next;

    // one extra bit so -32768 has a magnitude.
    assign abs_x = i_acc_x[ACC_W-1] ? -{i_acc_x[ACC_W-1], i_acc_x} :
                                       {i_acc_x[ACC_W-1], i_acc_x};

    always_comb begin
        mag = '0;
        for (int i = 0; i < WHEEL_BOUNDS; i++) begin
            if (abs_x > i_x_bound[i]) begin
                mag = mag + WHEEL_LEVEL_W'(1);
            end
        end
        if (i_acc_y > 0 && abs_x > i_x_bound[0]) begin
            level_next = WHEEL_TIPPED;
        end else if (i_acc_x < 0) begin
            level_next = -mag;
        end else begin
            level_next = mag;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_level  <= '0;
            o_update <= 1'b0;
        end else begin
            o_update <= i_sample_valid;
            if (i_sample_valid) begin
                o_level <= level_next;
            end
        end
    end

endmodule

/* rtl/pedal_quantizer.sv */
module pedal_quantizer (
    input  logic                                 i_clk,
    input  logic                                 i_arst_n,
    input  logic                                 i_sample_valid,
    input  logic signed [adxl_pkg::ACC_W-1:0]    i_acc,
    input  logic signed [adxl_pkg::ACC_W-1:0]    i_lower_bound [ctrl_pkg::PEDAL_BOUNDS],
    output logic [ctrl_pkg::PEDAL_LEVEL_W-1:0]   o_level,
    output logic                                 o_update
);
    import ctrl_pkg::*;

    logic [PEDAL_LEVEL_W-1:0] level_next;

    // first bound from index 0 that the sample is above.
    always_comb begin
        level_next = PEDAL_LEVEL_W'(PEDAL_BOUNDS);
        for (int i = PEDAL_BOUNDS - 1; i >= 0; i--) begin
            if (i_acc > i_lower_bound[i]) begin
                level_next = PEDAL_LEVEL_W'(i);
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_level  <= '0;
            o_update <= 1'b0;
        end else begin
            o_update <= i_sample_valid;
            if (i_sample_valid) begin
                o_level <= level_next;
            end
        end
    end

endmodule

/* rtl/adxl_sampler.sv */
module adxl_sampler (
    input  logic                                i_clk,
    input  logic                                i_arst_n,
    spi_byte_if.master                          bus,
    output logic                                o_sample_valid,
    output logic signed [adxl_pkg::ACC_W-1:0]   o_acc_x,
    output logic signed [adxl_pkg::ACC_W-1:0]   o_acc_y
);
    import adxl_pkg::*;

    sampler_state_e   state;
    logic [2:0]       byte_cnt;
    logic [GAP_W-1:0] gap_cnt;
    logic             pending;
    logic             last_byte;
    logic [7:0]       data_buf [READ_BYTES-1];

    // R/W and MB bits, then a 6-bit register address.
    function automatic logic [7:0] cmd_byte(adxl_cmd_e cmd, logic [7:0] addr);
        return {cmd, addr[5:0]};
    endfunction

    always_comb begin
        bus.tx_byte = 8'h00;
        bus.hold_cs = 1'b0;
        last_byte   = 1'b0;
        case (state)
            st_cfg_format: begin
                bus.tx_byte = (byte_cnt == 3'd0) ?
                              cmd_byte(cmd_write_single, REG_DATA_FORMAT) : FULL_RES_VALUE;
                bus.hold_cs = (byte_cnt == 3'd0);
                last_byte   = (byte_cnt == 3'd1);
            end
            st_cfg_power: begin
                bus.tx_byte = (byte_cnt == 3'd0) ?
                              cmd_byte(cmd_write_single, REG_POWER_CTL) : MEASURE_VALUE;
                bus.hold_cs = (byte_cnt == 3'd0);
                last_byte   = (byte_cnt == 3'd1);
            end
            st_read_cmd: begin
                bus.tx_byte = cmd_byte(cmd_read_multi, REG_DATAX0);
                bus.hold_cs = 1'b1;
                last_byte   = 1'b1;
            end
            st_read_data: begin
                last_byte   = (byte_cnt == 3'(READ_BYTES - 1));
                bus.hold_cs = !last_byte;
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state          <= st_cfg_format;
            byte_cnt       <= '0;
            gap_cnt        <= '0;
            pending        <= 1'b0;
            bus.start      <= 1'b0;
            o_sample_valid <= 1'b0;
            o_acc_x        <= '0;
            o_acc_y        <= '0;
        end else begin
            bus.start      <= 1'b0;
            o_sample_valid <= 1'b0;
            if (state == st_gap) begin
                gap_cnt <= gap_cnt + 1'b1;
                if (gap_cnt == GAP_W'(SAMPLE_GAP - 1)) begin
                    gap_cnt <= '0;
                    state   <= st_read_cmd;
                end
            end else if (!pending && !bus.busy) begin
                bus.start <= 1'b1;
                pending   <= 1'b1;
            end else if (bus.done) begin
                pending <= 1'b0;
                if (!last_byte) begin
                    byte_cnt <= byte_cnt + 1'b1;
                end else begin
                    byte_cnt <= '0;
                    case (state)
                        st_cfg_format: state <= st_cfg_power;
                        st_cfg_power:  state <= st_read_cmd;
                        st_read_cmd:   state <= st_read_data;
                        default: begin
                            // little-endian X0 X1 Y0 Y1.
                            state          <= st_gap;
                            o_sample_valid <= 1'b1;
                            o_acc_x        <= {data_buf[1], data_buf[0]};
                            o_acc_y        <= {bus.rx_byte, data_buf[2]};
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == st_read_data && bus.done && !last_byte) begin
            data_buf[byte_cnt[1:0]] <= bus.rx_byte;
        end
    end

endmodule

/* rtl/spi_byte_engine.sv */
module spi_byte_engine (
    input  logic       i_clk,
    input  logic       i_arst_n,
    spi_byte_if.engine bus,
    output logic       o_cs,
    output logic       o_spc,
    output logic       o_sdi,
    input  logic       i_sdo
);
    import adxl_pkg::*;

    logic                 active;
    logic                 tail;
    logic                 hold;
    logic                 accept;
    logic                 half_end;
    logic [SPC_DIV_W-1:0] div_cnt;
    logic [2:0]           bit_cnt;
    logic [7:0]           tx_sh;
    logic [7:0]           rx_sh;

    assign accept   = bus.start && !bus.busy;
    assign half_end = (div_cnt == SPC_DIV_W'(SPC_HALF - 1));

    assign bus.busy    = active | tail;
    assign bus.rx_byte = rx_sh;

    // mode 3: spc idles high, sdi moves on the falling edge.
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            active   <= 1'b0;
            tail     <= 1'b0;
            hold     <= 1'b0;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            o_cs     <= 1'b1;
            o_spc    <= 1'b1;
            o_sdi    <= 1'b0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            if (accept) begin
                active  <= 1'b1;
                tail    <= 1'b0;
                hold    <= bus.hold_cs;
                div_cnt <= '0;
                bit_cnt <= '0;
                o_cs    <= 1'b0;
                o_spc   <= 1'b0;
                o_sdi   <= bus.tx_byte[7];
            end else if (active) begin
                div_cnt <= half_end ? '0 : div_cnt + 1'b1;
                if (half_end) begin
                    if (!o_spc) begin
                        o_spc <= 1'b1;
                    end else if (bit_cnt == 3'd7) begin
                        // spc stays high after the last bit.
                        active   <= 1'b0;
                        tail     <= !hold;
                        bus.done <= 1'b1;
                    end else begin
                        o_spc   <= 1'b0;
                        o_sdi   <= tx_sh[7];
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            end else if (tail) begin
                // release cs half a period after the byte.
                div_cnt <= half_end ? '0 : div_cnt + 1'b1;
                if (half_end) begin
                    o_cs <= 1'b1;
                    tail <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            tx_sh <= {bus.tx_byte[6:0], 1'b0};
        end else if (active && half_end) begin
            if (!o_spc) begin
                rx_sh <= {rx_sh[6:0], i_sdo};
            end else begin
                tx_sh <= {tx_sh[6:0], 1'b0};
            end
        end
    end

endmodule

/* rtl/spi_byte_if.sv */
interface spi_byte_if;

    logic       start;
    logic [7:0] tx_byte;
    logic       hold_cs;
    logic       busy;
    logic       done;
    logic [7:0] rx_byte;

    modport master (output start, output tx_byte, output hold_cs,
                    input busy, input done, input rx_byte);

    modport engine (input start, input tx_byte, input hold_cs,
                    output busy, output done, output rx_byte);

endinterface

/* rtl/ctrl_pkg.sv */
package ctrl_pkg;

    // ==============================
    // pedal
    // ==============================
    localparam int PEDAL_BOUNDS  = 7;
    localparam int PEDAL_LEVEL_W = 3;

    // ==============================
    // wheel
    // ==============================
    localparam int WHEEL_BOUNDS  = 5;
    localparam int WHEEL_LEVEL_W = 4;

    // wheel turned past upright.
    localparam logic signed [WHEEL_LEVEL_W-1:0] WHEEL_TIPPED = 4'sd7;

endpackage

/* rtl/adxl_pkg.sv */
package adxl_pkg;

    // ==============================
    // spi timing
    // ==============================
    // system clocks per half spc period.
    localparam int SPC_HALF   = 4;
    localparam int SPC_DIV_W  = $clog2(SPC_HALF);
    // idle cycles between two read frames.
    localparam int SAMPLE_GAP = 64;
    localparam int GAP_W      = $clog2(SAMPLE_GAP);

    // ==============================
    // adxl345 register map
    // ==============================
    localparam logic [7:0] REG_POWER_CTL   = 8'h2D;
    localparam logic [7:0] REG_DATA_FORMAT = 8'h31;
    localparam logic [7:0] REG_DATAX0      = 8'h32;
    // full resolution, +/-16 g range.
    localparam logic [7:0] FULL_RES_VALUE  = 8'h0B;
    // measure bit only.
    localparam logic [7:0] MEASURE_VALUE   = 8'h08;

    // X0, X1, Y0, Y1 in one burst.
    localparam int READ_BYTES = 4;
    localparam int ACC_W      = 16;

    // encoded as the R/W and MB bits of the command byte.
    typedef enum logic [1:0] {
        cmd_write_single = 2'b00,
        cmd_read_multi   = 2'b11
    } adxl_cmd_e;

    typedef enum logic [2:0] {
        st_cfg_format,
        st_cfg_power,
        st_read_cmd,
        st_read_data,
        st_gap
    } sampler_state_e;

endpackage
